/* Bender.yml */
package:
  name: colmix

sources:
  # Design, package first
  - files:
      - source/colmix_pkg.sv
      - source/scroll_line_buf.sv
      - source/layer_priority.sv
      - source/line_sequencer.sv
      - source/colmix_top.sv

  # Testbench, includes the model header from bench
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/colmix_tb.sv

/* bench/colmix_tb_model.svh */
`ifndef colmix_tb_model_svh
`define colmix_tb_model_svh

// Shadow copies of the three line buffers
// Index 0 is scroll 1, index 2 is scroll 3
scr_pixel_t shadow_buf [3][512];

// Mirror one write that the mixer takes during fill
function automatic void store_pixel(input int layer, input scr_write_t w);
    shadow_buf[layer][w.addr] = w.pixel;
endfunction

// Palette address the mixer should send for position x
function automatic pal_addr_t expected_word(input int x);
    pal_addr_t  word;
    scr_pixel_t p1;
    scr_pixel_t p2;
    scr_pixel_t p3;
    p1 = shadow_buf[0][x];
    p2 = shadow_buf[1][x];
    p3 = shadow_buf[2][x];
    // First layer whose colour is not 0xF wins
    if (p1.col != 4'hf) begin
        word.layer = 3'd1;
        word.pixel = p1;
    end else if (p2.col != 4'hf) begin
        word.layer = 3'd2;
        word.pixel = p2;
    end else begin
        // Backdrop, drawn even when see-through
        word.layer = 3'd3;
        word.pixel = p3;
    end
    return word;
endfunction

`endif

/* bench/colmix_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module colmix_tb;

    import colmix_pkg::*;

    localparam int line_len  = 448;
    localparam int num_lines = 6;
    localparam int buf_depth = 512;
    // Write cycles, dump cycles and margin for every line
    localparam int timeout_cycles = num_lines * (3 * buf_depth + 4 * line_len + 200);

    logic        clk;
    logic        rst;
    logic        start;
    scr_write_t  scr1_wr;
    scr_write_t  scr2_wr;
    scr_write_t  scr3_wr;
    logic        scr1_valid;
    logic        scr2_valid;
    logic        scr3_valid;
    logic [2:0]  scr_done;
    line_write_t line_out;
    logic        line_valid;
    logic        line_ready;
    logic        line_done;

    // Pixels accepted on the current line
    int          xfer_count = 0;
    // line_done as the bench expects it
    logic        exp_done = 1'b0;
    // All three done pulses of the line have been driven
    logic        dones_all = 1'b0;
    // Output was stalled at the last edge, and its word then
    logic        held_valid = 1'b0;
    line_write_t held_out;
    int          cycle_count = 0;

    `include "colmix_tb_model.svh"

    colmix_top #(
        .line_len (line_len)
    ) i_colmix_top (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .scr1_wr    (scr1_wr),
        .scr2_wr    (scr2_wr),
        .scr3_wr    (scr3_wr),
        .scr1_valid (scr1_valid),
        .scr2_valid (scr2_valid),
        .scr3_valid (scr3_valid),
        .scr_done   (scr_done),
        .line_out   (line_out),
        .line_valid (line_valid),
        .line_ready (line_ready),
        .line_done  (line_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_value(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
        fail_run($sformatf("[FAIL] %s got %0h expected %0h", sig, got, exp));
    endtask

    function automatic scr_pixel_t random_pixel();
        scr_pixel_t p;
        p.pal = 5'($urandom);
        p.col = 4'($urandom);
        // Roughly a quarter see-through
        if ($urandom_range(0, 3) == 0) begin
            p.col = 4'hf;
        end
        return p;
    endfunction

    // Frame buffer ready about 70% of the time
    function automatic logic ready_roll();
        return ($urandom_range(0, 9) < 7);
    endfunction

    task automatic set_port(input int layer, input scr_write_t w, input logic v);
        case (layer)
            0: begin
                scr1_wr    = w;
                scr1_valid = v;
            end
            1: begin
                scr2_wr    = w;
                scr2_valid = v;
            end
            default: begin
                scr3_wr    = w;
                scr3_valid = v;
            end
        endcase
    endtask

    task automatic idle_ports();
        for (int l = 0; l < 3; l++) begin
            set_port(l, '0, 1'b0);
        end
        scr_done = '0;
        start    = 1'b0;
    endtask

    task automatic start_line();
        @(negedge clk);
        idle_ports();
        line_ready = ready_roll();
        start      = 1'b1;
        dones_all  = 1'b0;
    endtask

    task automatic fill_line();
        int unsigned order [3][buf_depth];
        int          left [3];
        int          wait_cycles [3];
        logic [2:0]  sent;
        int          cand [$];
        int          pick;
        int          j;
        int unsigned tmp;
        scr_write_t  w;
        // Each layer gets its own shuffled address order
        for (int l = 0; l < 3; l++) begin
            for (int a = 0; a < buf_depth; a++) begin
                order[l][a] = a;
            end
            for (int a = buf_depth - 1; a > 0; a--) begin
                j           = $urandom_range(0, a);
                tmp         = order[l][a];
                order[l][a] = order[l][j];
                order[l][j] = tmp;
            end
            left[l]        = buf_depth;
            wait_cycles[l] = 0;
        end
        sent = '0;
        while (sent != 3'b111) begin
            @(negedge clk);
            idle_ports();
            line_ready = ready_roll();
            cand.delete();
            for (int l = 0; l < 3; l++) begin
                if (left[l] > 0) begin
                    cand.push_back(l);
                end
            end
            // One write per cycle from a random layer
            if (cand.size() > 0) begin
                pick    = cand[$urandom_range(0, cand.size() - 1)];
                w.addr  = 9'(order[pick][buf_depth - left[pick]]);
                w.pixel = random_pixel();
                set_port(pick, w, 1'b1);
                store_pixel(pick, w);
                left[pick]--;
                if (left[pick] == 0) begin
                    wait_cycles[pick] = $urandom_range(0, 15);
                end
            end
            // Done pulse a random delay after the layer's last write
            for (int l = 0; l < 3; l++) begin
                if (left[l] == 0 && !sent[l]) begin
                    if (wait_cycles[l] == 0) begin
                        scr_done[l] = 1'b1;
                        sent[l]     = 1'b1;
                    end else begin
                        wait_cycles[l]--;
                    end
                end
            end
        end
        dones_all = 1'b1;
    endtask

    task automatic dump_line();
        scr_write_t w;
        // Quiet so stray writes only start once dump has begun
        repeat (2) begin
            @(negedge clk);
            idle_ports();
            line_ready = ready_roll();
        end
        while (!exp_done) begin
            @(negedge clk);
            idle_ports();
            line_ready = ready_roll();
            // Writes aimed at positions not yet read, must be dropped
            for (int l = 0; l < 3; l++) begin
                if ($urandom_range(0, 2) == 0) begin
                    w.addr  = 9'($urandom_range(xfer_count, buf_depth - 1));
                    w.pixel = random_pixel();
                    set_port(l, w, 1'b1);
                end
            end
        end
        // Output has to stay quiet after the line
        repeat (8) begin
            @(negedge clk);
            idle_ports();
            line_ready = ready_roll();
        end
    endtask

    // Checker, samples at the rising edge before the DUT updates
    always @(posedge clk) begin
        if (rst) begin
            xfer_count = 0;
            exp_done   = 1'b0;
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                assert (line_valid)
                    else fail_run("line_valid dropped while the frame buffer stalled");
                assert (line_out == held_out)
                    else report_value("line_out", line_out, held_out);
            end
            if (!dones_all) begin
                assert (!line_valid)
                    else fail_run("pixel sent before all three layers reported done");
            end
            assert (line_done == exp_done)
                else report_value("line_done", line_done, exp_done);
            if (exp_done) begin
                assert (!line_valid)
                    else fail_run("line_valid high after the end of the line");
            end
            if (line_valid && line_ready) begin
                assert (line_out.addr == 9'(xfer_count))
                    else report_value("line_out.addr", line_out.addr, xfer_count);
                assert (line_out.data == expected_word(xfer_count))
                    else report_value("line_out.data", line_out.data,
                                      expected_word(xfer_count));
                xfer_count++;
            end
            held_valid = line_valid && !line_ready && !start;
            held_out   = line_out;
            if (start) begin
                exp_done   = 1'b0;
                xfer_count = 0;
            end else if (xfer_count == line_len) begin
                exp_done = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count < timeout_cycles)
            else fail_run("timeout, the lines did not finish in the allowed cycles");
    end

    initial begin
        void'($urandom(50113));
        rst        = 1'b1;
        start      = 1'b0;
        scr1_wr    = '0;
        scr2_wr    = '0;
        scr3_wr    = '0;
        scr1_valid = 1'b0;
        scr2_valid = 1'b0;
        scr3_valid = 1'b0;
        scr_done   = '0;
        line_ready = 1'b0;
        repeat (16) @(negedge clk);
        // Outputs idle while reset is still held
        assert (!line_valid) else report_value("line_valid", line_valid, 0);
        assert (!line_done) else report_value("line_done", line_done, 0);
        rst = 1'b0;
        for (int n = 0; n < num_lines; n++) begin
            // First line runs straight from reset
            if (n > 0) begin
                start_line();
            end
            fill_line();
            dump_line();
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
source/colmix_pkg.sv
source/scroll_line_buf.sv
source/layer_priority.sv
source/line_sequencer.sv
source/colmix_top.sv
bench/colmix_tb.sv

/* source/colmix_pkg.sv */
`default_nettype none

package colmix_pkg;

    // Line buffer address width, 512 entries per layer
    localparam int buf_addr_w = 9;

    // Colour value that lets the layer below show through
    localparam logic [3:0] transparent_col = 4'hf;

    // Layer code written in the top bits of the palette address
    typedef logic [2:0] layer_t;

    // Codes of the three scroll layers
    localparam layer_t scr1_code = 3'd1;
    localparam layer_t scr2_code = 3'd2;
    localparam layer_t scr3_code = 3'd3;

    // One tile engine pixel
    typedef struct packed {
        // Palette number
        logic [4:0] pal;
        // Colour within the palette, 0xF is see-through
        logic [3:0] col;
    } scr_pixel_t;

    // Palette address sent to the frame buffer
    typedef struct packed {
        // Which layer won the priority test
        layer_t     layer;
        // Winning pixel, unchanged
        scr_pixel_t pixel;
    } pal_addr_t;

    // One write from a tile engine into its line buffer
    typedef struct packed {
        // X position on the line
        logic [buf_addr_w-1:0] addr;
        scr_pixel_t            pixel;
    } scr_write_t;

    // One pixel for the frame buffer
    typedef struct packed {
        // X position on the line
        logic [buf_addr_w-1:0] addr;
        // Palette address at that position
        pal_addr_t             data;
    } line_write_t;

endpackage

`default_nettype wire

/* source/colmix_top.sv */
`timescale 1ns/1ps
`default_nettype none

module colmix_top #(
    parameter int line_len = 448
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  colmix_pkg::scr_write_t  scr1_wr,
    input  colmix_pkg::scr_write_t  scr2_wr,
    input  colmix_pkg::scr_write_t  scr3_wr,
    input  logic                    scr1_valid,
    input  logic                    scr2_valid,
    input  logic                    scr3_valid,
    input  logic [2:0]              scr_done,
    output colmix_pkg::line_write_t line_out,
    output logic                    line_valid,
    input  logic                    line_ready,
    output logic                    line_done
);

    import colmix_pkg::*;

    // Gated write enables from the sequencer
    logic scr1_wr_en;
    logic scr2_wr_en;
    logic scr3_wr_en;

    // Shared read address and stage enables
    logic [buf_addr_w-1:0] rd_addr;
    logic                  rd_en;
    logic                  pri_en;

    // Buffer outputs into the priority stage
    scr_pixel_t scr1_pixel;
    scr_pixel_t scr2_pixel;
    scr_pixel_t scr3_pixel;

    // Registered palette address back to the sequencer
    pal_addr_t pal_addr;

    // Scroll 1 line buffer
    scroll_line_buf i_scr1_buf (
        .clk      (clk),
        .rst      (rst),
        .wr       (scr1_wr),
        .wr_en    (scr1_wr_en),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_pixel (scr1_pixel)
    );

    // Scroll 2 line buffer
    scroll_line_buf i_scr2_buf (
        .clk      (clk),
        .rst      (rst),
        .wr       (scr2_wr),
        .wr_en    (scr2_wr_en),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_pixel (scr2_pixel)
    );

    // Scroll 3 line buffer, the backdrop
    scroll_line_buf i_scr3_buf (
        .clk      (clk),
        .rst      (rst),
        .wr       (scr3_wr),
        .wr_en    (scr3_wr_en),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_pixel (scr3_pixel)
    );

    layer_priority i_layer_priority (
        .clk        (clk),
        .rst        (rst),
        .scr1_pixel (scr1_pixel),
        .scr2_pixel (scr2_pixel),
        .scr3_pixel (scr3_pixel),
        .en         (pri_en),
        .pal_addr   (pal_addr)
    );

    line_sequencer #(
        .line_len (line_len)
    ) i_line_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .scr_done   (scr_done),
        .scr1_valid (scr1_valid),
        .scr2_valid (scr2_valid),
        .scr3_valid (scr3_valid),
        .scr1_wr_en (scr1_wr_en),
        .scr2_wr_en (scr2_wr_en),
        .scr3_wr_en (scr3_wr_en),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .pri_en     (pri_en),
        .pal_addr   (pal_addr),
        .line_out   (line_out),
        .line_valid (line_valid),
        .line_ready (line_ready),
        .line_done  (line_done)
    );

endmodule

`default_nettype wire

/* source/layer_priority.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_priority (
    input  logic                   clk,
    input  logic                   rst,
    input  colmix_pkg::scr_pixel_t scr1_pixel,
    input  colmix_pkg::scr_pixel_t scr2_pixel,
    input  colmix_pkg::scr_pixel_t scr3_pixel,
    input  logic                   en,
    output colmix_pkg::pal_addr_t  pal_addr
);

    import colmix_pkg::*;

    // Opaque flags for the two upper layers
    logic scr1_opaque;
    logic scr2_opaque;

    // Combinational choice before the register
    pal_addr_t pick;

    assign scr1_opaque = (scr1_pixel.col != transparent_col);
    assign scr2_opaque = (scr2_pixel.col != transparent_col);

    // Fixed order scroll 1, scroll 2, scroll 3
    // Scroll 3 is the backdrop, so its colour is never tested
    always_comb begin
        if (scr1_opaque) begin
            pick.layer = scr1_code;
            pick.pixel = scr1_pixel;
        end else if (scr2_opaque) begin
            pick.layer = scr2_code;
            pick.pixel = scr2_pixel;
        end else begin
            pick.layer = scr3_code;
            pick.pixel = scr3_pixel;
        end
    end

    // Priority register, doubles as the output stage of the pipeline
    // Holds while en is low so line_out stays put under back-pressure
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_addr <= '0;
        end else if (en) begin
            pal_addr <= pick;
        end
    end

endmodule

`default_nettype wire

/* source/line_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_sequencer #(
    parameter int line_len = 448
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic [2:0]                          scr_done,
    input  logic                                scr1_valid,
    input  logic                                scr2_valid,
    input  logic                                scr3_valid,
    output logic                                scr1_wr_en,
    output logic                                scr2_wr_en,
    output logic                                scr3_wr_en,
    output logic [colmix_pkg::buf_addr_w-1:0]   rd_addr,
    output logic                                rd_en,
    output logic                                pri_en,
    input  colmix_pkg::pal_addr_t               pal_addr,
    output colmix_pkg::line_write_t             line_out,
    output logic                                line_valid,
    input  logic                                line_ready,
    output logic                                line_done
);

    import colmix_pkg::*;

    // X position of the last pixel on the line
    localparam logic [buf_addr_w-1:0] last_x = buf_addr_w'(line_len - 1);

    // Phase, low = fill, high = dump
    logic                  dump;
    // One latch per layer, set by its done pulse
    logic [2:0]            done_q;
    // Next x position to read
    logic [buf_addr_w-1:0] rd_addr_q;
    // Every address of the line has been issued
    logic                  issue_done;
    // Read stage and priority stage valid bits
    logic                  rd_valid;
    logic                  pri_valid;
    // X position carried alongside each stage
    logic [buf_addr_w-1:0] rd_x;
    logic [buf_addr_w-1:0] pri_x;

    logic advance;
    logic issue;
    logic last_xfer;

    // Layer writes only land during fill, dump drops them
    assign scr1_wr_en = scr1_valid && !dump;
    assign scr2_wr_en = scr2_valid && !dump;
    assign scr3_wr_en = scr3_valid && !dump;

    // Whole pipeline moves when the output is empty or being taken
    assign advance = !pri_valid || line_ready;
    assign rd_en   = advance;
    assign pri_en  = advance;

    // A new address enters the read stage on this advance
    assign issue = dump && !issue_done;

    // Final pixel of the line accepted by the frame buffer
    assign last_xfer = pri_valid && line_ready && (pri_x == last_x);

    assign rd_addr    = rd_addr_q;
    assign line_valid = pri_valid;

    // Output word comes straight from the priority register
    always_comb begin
        line_out.addr = pri_x;
        line_out.data = pal_addr;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dump       <= 1'b0;
            done_q     <= '0;
            rd_addr_q  <= '0;
            issue_done <= 1'b0;
            rd_valid   <= 1'b0;
            pri_valid  <= 1'b0;
            line_done  <= 1'b0;
        end else if (start) begin
            // Back to fill, also abandons a dump in progress
            dump       <= 1'b0;
            done_q     <= '0;
            rd_addr_q  <= '0;
            issue_done <= 1'b0;
            rd_valid   <= 1'b0;
            pri_valid  <= 1'b0;
            line_done  <= 1'b0;
        end else begin
            if (!dump) begin
                // Pulses may come in any order
                done_q <= done_q | scr_done;
                // Enter dump the cycle after the last latch sets
                if (&done_q) begin
                    dump       <= 1'b1;
                    rd_addr_q  <= '0;
                    issue_done <= 1'b0;
                end
            end
            if (advance) begin
                rd_valid  <= issue;
                pri_valid <= rd_valid;
                if (issue) begin
                    // Counter parks on the last x once it is issued
                    if (rd_addr_q == last_x) begin
                        issue_done <= 1'b1;
                    end else begin
                        rd_addr_q <= rd_addr_q + 1'b1;
                    end
                end
            end
            // Held until the next start
            if (last_xfer) begin
                line_done <= 1'b1;
            end
        end
    end

    // X copies follow the valid bits through the pipeline
    always_ff @(posedge clk) begin
        if (advance) begin
            rd_x  <= rd_addr_q;
            pri_x <= rd_x;
        end
    end

endmodule

`default_nettype wire

/* source/scroll_line_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module scroll_line_buf (
    input  logic                                clk,
    input  logic                                rst,
    input  colmix_pkg::scr_write_t              wr,
    input  logic                                wr_en,
    input  logic [colmix_pkg::buf_addr_w-1:0]   rd_addr,
    input  logic                                rd_en,
    output colmix_pkg::scr_pixel_t              rd_pixel
);

    import colmix_pkg::*;

    // Number of entries follows from the address width
    localparam int depth = 1 << buf_addr_w;

    // One scan line of a single layer
    scr_pixel_t mem [depth];

    // Write port, fill phase gating is already folded into wr_en
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr.addr] <= wr.pixel;
        end
    end

    // Registered read port
    // Holds its value while rd_en is low so a stall keeps the pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Comes out of reset as a see-through pixel
            rd_pixel.pal <= '0;
            rd_pixel.col <= transparent_col;
        end else if (rd_en) begin
            rd_pixel <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire
